// File: files.f
+incdir+include
verilog/pf_isa_pkg.sv
verilog/pf_regmap_pkg.sv
verilog/pf_if.sv
verilog/filt_regs.sv
verilog/inst_loader.sv
verilog/packet_buffer.sv
verilog/bpf_alu.sv
verilog/bpf_control.sv
verilog/packetfilt.sv
verif/packetfilt_tb.sv

// File: include/packetfilt_settings.svh
`ifndef PACKETFILT_SETTINGS_SVH
`define PACKETFILT_SETTINGS_SVH

// AXI4-Lite register window
`define PF_AXI_ADDR_WIDTH 12

// Code memory holds 2**6 instructions
`define PF_CODE_ADDR_WIDTH 6

// Packet buffer of 64 words or 256 bytes
`define PF_PKT_ADDR_WIDTH 6
`define PF_PKT_DATA_WIDTH 32
`define PF_PKT_LEN_WIDTH (`PF_PKT_ADDR_WIDTH + 1) // Length in words, a full buffer fits
`define PF_PKT_BYTES_WIDTH (`PF_PKT_ADDR_WIDTH + 3) // Length in bytes

`endif

// File: run.sh
#!/bin/sh
# Build and run the packet filter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module packetfilt_tb -f files.f -o packetfilt_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/packetfilt_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi
cat sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
exit 0

// File: verif/packetfilt_tb.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module packetfilt_tb;
	localparam int TIMEOUT_CYCLES = 500; // Per wait loop

	logic clk;
	logic rst_n;
	logic [`PF_AXI_ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`PF_AXI_ADDR_WIDTH-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [`PF_PKT_ADDR_WIDTH-1:0] snooper_wr_addr;
	logic [`PF_PKT_DATA_WIDTH-1:0] snooper_wr_data;
	logic snooper_wr_en;
	logic snooper_done;
	logic ready_for_snooper;
	logic [`PF_PKT_ADDR_WIDTH-1:0] forwarder_rd_addr;
	logic [`PF_PKT_DATA_WIDTH-1:0] forwarder_rd_data;
	logic forwarder_rd_en;
	logic forwarder_done;
	logic ready_for_forwarder;
	logic [`PF_PKT_LEN_WIDTH-1:0] len_to_forwarder;

	logic [31:0] lfsr_state;
	logic [31:0] pkt_words [64]; // Payload of the packet under test
	logic [63:0] program_code [$];
	string cur_test;
	int checks;
	int errors;
	int test_errors_at_start;

	packetfilt u_dut (
		.axi_aclk(clk), .rst_n(rst_n),
		.s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
		.s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
		.s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
		.s_axi_araddr(araddr), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
		.s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rvalid(rvalid), .s_axi_rready(rready),
		.snooper_wr_addr(snooper_wr_addr), .snooper_wr_data(snooper_wr_data),
		.snooper_wr_en(snooper_wr_en), .snooper_done(snooper_done),
		.ready_for_snooper(ready_for_snooper),
		.forwarder_rd_addr(forwarder_rd_addr), .forwarder_rd_data(forwarder_rd_data),
		.forwarder_rd_en(forwarder_rd_en), .forwarder_done(forwarder_done),
		.ready_for_forwarder(ready_for_forwarder), .len_to_forwarder(len_to_forwarder)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	// Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_word();
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			val = {val[30:0], lfsr_state[0]};
		end
		random_word = val;
	endfunction

	function automatic logic [63:0] make_inst(input logic [15:0] opcode, input logic [7:0] jt,
			input logic [7:0] jf, input logic [31:0] k);
		make_inst = {opcode, jt, jf, k};
	endfunction

	task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("FAIL %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR %s: timed out waiting for %s", cur_test, what);
		errors++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors_at_start = errors;
	endtask

	task automatic finish_test();
		$display("test %s finished with %0d errors", cur_test, errors - test_errors_at_start);
	endtask

	task automatic axi_write(input logic [`PF_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int cnt;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		bready <= 1'b1;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!awready && cnt < TIMEOUT_CYCLES);
		if (!awready)
			report_timeout("awready");
		else
			check_equal("wready with awready", 32'd1, 32'(wready));
		@(posedge clk);
		awvalid <= 1'b0; // Address and data taken on this edge
		wvalid <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!bvalid && cnt < TIMEOUT_CYCLES);
		if (!bvalid)
			report_timeout("bvalid");
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`PF_AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int cnt;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!arready && cnt < TIMEOUT_CYCLES);
		if (!arready)
			report_timeout("arready");
		@(posedge clk);
		arvalid <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!rvalid && cnt < TIMEOUT_CYCLES);
		if (!rvalid)
			report_timeout("rvalid");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_reg(input logic [`PF_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_equal("write response", 32'(pf_regmap_pkg::OKAY), 32'(resp));
	endtask

	task automatic expect_reg(input string what, input logic [`PF_AXI_ADDR_WIDTH-1:0] addr,
			input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_equal({what, " response"}, 32'(pf_regmap_pkg::OKAY), 32'(resp));
		check_equal(what, exp, data);
	endtask

	// Start high rewinds the loader and start low lets it take instructions
	task automatic load_program();
		int i;
		write_reg(pf_regmap_pkg::CONTROL, 32'd1);
		write_reg(pf_regmap_pkg::CONTROL, 32'd0);
		for (i = 0; i < program_code.size(); i++) begin
			write_reg(pf_regmap_pkg::INST_LOW, program_code[i][31:0]);
			write_reg(pf_regmap_pkg::INST_HIGH, program_code[i][63:32]); // Commits the pair
		end
		write_reg(pf_regmap_pkg::CONTROL, 32'd1);
	endtask

	task automatic fill_packet(input int n);
		int i;
		for (i = 0; i < n; i++)
			pkt_words[i] = random_word();
	endtask

	// Writes a packet as the snooper and returns the verdict seen on the ready flags
	task automatic send_packet(input int n, output logic accepted);
		int cnt;
		int i;
		cnt = 0;
		while (!ready_for_snooper && cnt < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cnt++;
		end
		if (!ready_for_snooper)
			report_timeout("ready_for_snooper before sending");
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			snooper_wr_addr <= `PF_PKT_ADDR_WIDTH'(i);
			snooper_wr_data <= pkt_words[i];
			snooper_wr_en <= 1'b1;
		end
		@(posedge clk);
		snooper_wr_en <= 1'b0;
		snooper_done <= 1'b1;
		@(posedge clk);
		snooper_done <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!ready_for_forwarder && !ready_for_snooper && cnt < TIMEOUT_CYCLES);
		if (!ready_for_forwarder && !ready_for_snooper)
			report_timeout("a filter verdict");
		accepted = ready_for_forwarder;
	endtask

	// Reads every word back as the forwarder and releases the buffer
	task automatic forward_packet(input int n);
		int cnt;
		int i;
		check_equal("len_to_forwarder", 32'(n), 32'(len_to_forwarder));
		for (i = 0; i < n; i++) begin
			@(posedge clk);
			forwarder_rd_addr <= `PF_PKT_ADDR_WIDTH'(i);
			forwarder_rd_en <= 1'b1;
			@(posedge clk);
			forwarder_rd_en <= 1'b0;
			@(negedge clk); // Data one cycle after the address
			check_equal($sformatf("forwarded word %0d", i), pkt_words[i], forwarder_rd_data);
		end
		check_equal("ready_for_snooper before done", 32'd0, 32'(ready_for_snooper));
		@(posedge clk);
		forwarder_done <= 1'b1;
		@(posedge clk);
		forwarder_done <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!ready_for_snooper && cnt < TIMEOUT_CYCLES);
		if (!ready_for_snooper)
			report_timeout("ready_for_snooper after forwarding");
	endtask

	task automatic test_register_access();
		logic [31:0] data;
		logic [1:0] resp;
		start_test("register_access");
		check_equal("ready_for_snooper after reset", 32'd1, 32'(ready_for_snooper));
		check_equal("ready_for_forwarder after reset", 32'd0, 32'(ready_for_forwarder));
		check_equal("awready after reset", 32'd0, 32'(awready));
		check_equal("wready after reset", 32'd0, 32'(wready));
		check_equal("bvalid after reset", 32'd0, 32'(bvalid));
		check_equal("arready after reset", 32'd0, 32'(arready));
		check_equal("rvalid after reset", 32'd0, 32'(rvalid));
		expect_reg("status after reset", pf_regmap_pkg::STATUS, 32'd0);
		expect_reg("control after reset", pf_regmap_pkg::CONTROL, 32'd0);
		write_reg(pf_regmap_pkg::CONTROL, 32'h1234_5671);
		expect_reg("control readback", pf_regmap_pkg::CONTROL, 32'h1234_5671);
		write_reg(pf_regmap_pkg::CONTROL, 32'd0);
		expect_reg("control cleared", pf_regmap_pkg::CONTROL, 32'd0);
		write_reg(pf_regmap_pkg::INST_LOW, 32'hCAFE_F00D);
		expect_reg("inst_low readback", pf_regmap_pkg::INST_LOW, 32'hCAFE_F00D);
		write_reg(pf_regmap_pkg::INST_HIGH, 32'h0028_0102);
		expect_reg("inst_high readback", pf_regmap_pkg::INST_HIGH, 32'h0028_0102);
		axi_write(12'h010, 32'hFFFF_FFFF, resp);
		check_equal("unmapped write response", 32'(pf_regmap_pkg::SLVERR), 32'(resp));
		axi_read(12'h010, data, resp);
		check_equal("unmapped read response", 32'(pf_regmap_pkg::SLVERR), 32'(resp));
		finish_test();
	endtask

	// Ethertype match on bytes 12 and 13
	task automatic load_ethertype_program();
		program_code.delete();
		program_code.push_back(make_inst(pf_isa_pkg::LD_H_ABS, 8'd0, 8'd0, 32'd12));
		program_code.push_back(make_inst(pf_isa_pkg::JEQ_K, 8'd0, 8'd1, 32'h0800));
		program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd1));
		program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd0));
		load_program();
	endtask

	task automatic test_accept_path();
		logic accepted;
		start_test("accept_path");
		load_ethertype_program();
		fill_packet(16);
		pkt_words[3][31:16] = 16'h0800;
		send_packet(16, accepted);
		check_equal("verdict", 32'd1, 32'(accepted));
		if (accepted)
			forward_packet(16);
		check_equal("ready_for_snooper after done", 32'd1, 32'(ready_for_snooper));
		finish_test();
	endtask

	task automatic test_reject_path();
		logic accepted;
		int i;
		start_test("reject_path");
		expect_reg("status before rejects", pf_regmap_pkg::STATUS, 32'd0);
		for (i = 0; i < 3; i++) begin
			fill_packet(8 + i);
			pkt_words[3][31:16] = 16'h86DD; // Not the matched ethertype
			send_packet(8 + i, accepted);
			check_equal("verdict", 32'd0, 32'(accepted));
			check_equal("ready_for_snooper", 32'd1, 32'(ready_for_snooper));
			expect_reg("drop count", pf_regmap_pkg::STATUS, 32'(i + 1));
		end
		finish_test();
	endtask

	task automatic test_length_arith();
		int lens [6];
		int i;
		int rejects;
		logic [31:0] a;
		logic accepted;
		logic exp_accept;
		start_test("length_arith");
		lens = '{3, 9, 10, 12, 15, 16};
		rejects = 0;
		program_code.delete();
		program_code.push_back(make_inst(pf_isa_pkg::LD_LEN, 8'd0, 8'd0, 32'd0));
		program_code.push_back(make_inst(pf_isa_pkg::ALU_AND_K, 8'd0, 8'd0, 32'h3C));
		program_code.push_back(make_inst(pf_isa_pkg::ALU_ADD_K, 8'd0, 8'd0, 32'd4));
		program_code.push_back(make_inst(pf_isa_pkg::JGT_K, 8'd0, 8'd1, 32'd40));
		program_code.push_back(make_inst(pf_isa_pkg::RET_A, 8'd0, 8'd0, 32'd0));
		program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd0));
		load_program();
		for (i = 0; i < 6; i++) begin
			a = 32'(lens[i] * 4) & 32'h3C; // Masked length in bytes
			a = a + 32'd4;
			exp_accept = (a > 32'd40);
			if (!exp_accept)
				rejects++;
			fill_packet(lens[i]);
			send_packet(lens[i], accepted);
			check_equal($sformatf("verdict for %0d words", lens[i]), 32'(exp_accept),
				32'(accepted));
			if (accepted)
				forward_packet(lens[i]);
		end
		expect_reg("drop count", pf_regmap_pkg::STATUS, 32'(rejects));
		finish_test();
	endtask

	task automatic test_byte_select();
		logic [31:0] masks [2];
		logic [31:0] b;
		logic accepted;
		logic exp_accept;
		int m;
		int o;
		start_test("byte_select");
		masks = '{32'h04, 32'h09};
		for (m = 0; m < 2; m++) begin
			for (o = 0; o < 4; o++) begin
				program_code.delete();
				program_code.push_back(make_inst(pf_isa_pkg::LD_B_ABS, 8'd0, 8'd0, 32'(4 + o)));
				program_code.push_back(make_inst(pf_isa_pkg::JSET_K, 8'd0, 8'd1, masks[m]));
				program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd1));
				program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd0));
				load_program();
				fill_packet(4);
				pkt_words[1] = 32'h0102_0408;
				b = (pkt_words[1] >> (8 * (3 - o))) & 32'hFF; // Byte 0 is the top byte
				exp_accept = ((b & masks[m]) != 32'd0);
				send_packet(4, accepted);
				check_equal($sformatf("verdict mask %0h offset %0d", masks[m], o),
					32'(exp_accept), 32'(accepted));
				if (accepted)
					forward_packet(4);
			end
		end
		finish_test();
	endtask

	task automatic test_illegal_cases();
		logic accepted;
		start_test("illegal_cases");
		// Word at byte 16 of a 16-byte packet
		program_code.delete();
		program_code.push_back(make_inst(pf_isa_pkg::LD_W_ABS, 8'd0, 8'd0, 32'd16));
		program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd1));
		load_program();
		fill_packet(4);
		send_packet(4, accepted);
		check_equal("out of bounds verdict", 32'd0, 32'(accepted));
		expect_reg("drop count after bounds reject", pf_regmap_pkg::STATUS, 32'd1);
		program_code.delete();
		program_code.push_back(make_inst(16'h0099, 8'd0, 8'd0, 32'd1)); // Not in the ISA
		program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd1));
		load_program();
		fill_packet(4);
		send_packet(4, accepted);
		check_equal("unknown opcode verdict", 32'd0, 32'(accepted));
		expect_reg("drop count after opcode reject", pf_regmap_pkg::STATUS, 32'd1);
		program_code.delete();
		program_code.push_back(make_inst(pf_isa_pkg::RET_K, 8'd0, 8'd0, 32'd1));
		load_program();
		expect_reg("drop count after reload", pf_regmap_pkg::STATUS, 32'd0);
		fill_packet(5);
		send_packet(5, accepted);
		check_equal("reloaded program verdict", 32'd1, 32'(accepted));
		if (accepted)
			forward_packet(5);
		finish_test();
	endtask

	initial begin
		rst_n <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= 4'hF; // Ignored by the DUT
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		snooper_wr_addr <= '0;
		snooper_wr_data <= '0;
		snooper_wr_en <= 1'b0;
		snooper_done <= 1'b0;
		forwarder_rd_addr <= '0;
		forwarder_rd_en <= 1'b0;
		forwarder_done <= 1'b0;
		lfsr_state = 32'hd210;
		checks = 0;
		errors = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		test_register_access();
		test_accept_path();
		test_reject_path();
		test_length_arith();
		test_byte_select();
		test_illegal_cases();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: verilog/bpf_alu.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module bpf_alu (
	input  logic clk,
	input  logic rst_n,
	alu_if.target alu,
	input  logic [`PF_PKT_DATA_WIDTH-1:0] pkt_word
);
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	// Big-endian lanes, byte 0 is the top byte
	always_comb begin
		case (alu.byte_off)
			2'd0: byte_sel = pkt_word[31:24];
			2'd1: byte_sel = pkt_word[23:16];
			2'd2: byte_sel = pkt_word[15:8];
			default: byte_sel = pkt_word[7:0];
		endcase
	end

	// Half-word at offset 3 wraps inside the same word
	always_comb begin
		case (alu.byte_off)
			2'd0: half_sel = pkt_word[31:16];
			2'd1: half_sel = pkt_word[23:8];
			2'd2: half_sel = pkt_word[15:0];
			default: half_sel = {pkt_word[7:0], pkt_word[31:24]};
		endcase
	end

	// Accumulator
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu.acc <= 32'd0;
		end else begin
			case (alu.op)
				pf_isa_pkg::LOAD_K: alu.acc <= alu.k;
				pf_isa_pkg::LOAD_B: alu.acc <= {24'd0, byte_sel};
				pf_isa_pkg::LOAD_H: alu.acc <= {16'd0, half_sel};
				pf_isa_pkg::LOAD_W: alu.acc <= pkt_word;
				pf_isa_pkg::ADD_K: alu.acc <= alu.acc + alu.k; // Wraps at 32 bits
				pf_isa_pkg::AND_K: alu.acc <= alu.acc & alu.k;
				default: alu.acc <= alu.acc;
			endcase
		end
	end

	// Jump conditions, unsigned
	assign alu.eq_k = (alu.acc == alu.k);
	assign alu.gt_k = (alu.acc > alu.k);
	assign alu.set_k = |(alu.acc & alu.k);

endmodule

// File: verilog/bpf_control.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module bpf_control (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic [`PF_CODE_ADDR_WIDTH-1:0] fetch_addr,
	input  pf_isa_pkg::bpf_inst_t inst,
	alu_if.initiator alu,
	pkt_if.initiator pkt,
	output logic [15:0] drops
);
	pf_isa_pkg::vm_state_e state;
	logic [`PF_CODE_ADDR_WIDTH-1:0] pc;
	logic [`PF_CODE_ADDR_WIDTH-1:0] pc_next;
	logic [7:0] jump_off; // Zero for anything but a jump
	logic is_load;
	logic [2:0] load_size;
	logic [32:0] load_end;
	logic load_oob;
	logic ret_accept;
	logic verdict_accept;

	assign fetch_addr = pc;
	assign pc_next = pc + 1'b1 + `PF_CODE_ADDR_WIDTH'(jump_off);
	assign pkt.rd_addr = inst.k[`PF_PKT_ADDR_WIDTH+1:2]; // Word holding byte k
	assign alu.byte_off = inst.k[1:0];
	assign alu.pkt_len_bytes = {pkt.len_words, 2'b00};
	assign alu.k = (inst.opcode == pf_isa_pkg::LD_LEN) ? 32'(alu.pkt_len_bytes) : inst.k;

	// Load width and bounds
	always_comb begin
		is_load = 1'b1;
		case (inst.opcode)
			pf_isa_pkg::LD_B_ABS: load_size = 3'd1;
			pf_isa_pkg::LD_H_ABS: load_size = 3'd2;
			pf_isa_pkg::LD_W_ABS: load_size = 3'd4;
			default: begin
				is_load = 1'b0;
				load_size = 3'd0;
			end
		endcase
	end
	assign load_end = {1'b0, inst.k} + 33'(load_size);
	assign load_oob = load_end > 33'(alu.pkt_len_bytes); // Past the last byte

	// Branch offset
	always_comb begin
		case (inst.opcode)
			pf_isa_pkg::JEQ_K: jump_off = alu.eq_k ? inst.jt : inst.jf;
			pf_isa_pkg::JGT_K: jump_off = alu.gt_k ? inst.jt : inst.jf;
			pf_isa_pkg::JSET_K: jump_off = alu.set_k ? inst.jt : inst.jf;
			default: jump_off = 8'd0;
		endcase
	end

	assign ret_accept = (inst.opcode == pf_isa_pkg::RET_A) ? (alu.acc != 32'd0) : (inst.k != 32'd0);

	// ALU command, EXEC for immediate ops and LOAD for packet data
	always_comb begin
		alu.op = pf_isa_pkg::HOLD;
		if (state == pf_isa_pkg::EXEC) begin
			case (inst.opcode)
				pf_isa_pkg::LD_IMM, pf_isa_pkg::LD_LEN: alu.op = pf_isa_pkg::LOAD_K;
				pf_isa_pkg::ALU_ADD_K: alu.op = pf_isa_pkg::ADD_K;
				pf_isa_pkg::ALU_AND_K: alu.op = pf_isa_pkg::AND_K;
				default: alu.op = pf_isa_pkg::HOLD;
			endcase
		end else if (state == pf_isa_pkg::LOAD) begin
			case (inst.opcode)
				pf_isa_pkg::LD_B_ABS: alu.op = pf_isa_pkg::LOAD_B;
				pf_isa_pkg::LD_H_ABS: alu.op = pf_isa_pkg::LOAD_H;
				default: alu.op = pf_isa_pkg::LOAD_W;
			endcase
		end
	end

	// Sequencer, parked in IDLE while stopped
	always_ff @(posedge clk) begin
		if (!rst_n || !start) begin
			state <= pf_isa_pkg::IDLE;
			pc <= '0;
			verdict_accept <= 1'b0;
		end else begin
			case (state)
				pf_isa_pkg::IDLE: begin
					pc <= '0;
					if (pkt.pkt_ready)
						state <= pf_isa_pkg::FETCH;
				end
				pf_isa_pkg::FETCH: state <= pf_isa_pkg::EXEC; // Code memory latency
				pf_isa_pkg::EXEC: begin
					if (is_load) begin
						verdict_accept <= 1'b0;
						state <= load_oob ? pf_isa_pkg::VERDICT : pf_isa_pkg::LOAD;
					end else begin
						case (inst.opcode)
							pf_isa_pkg::LD_IMM, pf_isa_pkg::LD_LEN, pf_isa_pkg::ALU_ADD_K,
							pf_isa_pkg::ALU_AND_K, pf_isa_pkg::JEQ_K, pf_isa_pkg::JGT_K,
							pf_isa_pkg::JSET_K: begin
								pc <= pc_next;
								state <= pf_isa_pkg::FETCH;
							end
							pf_isa_pkg::RET_K, pf_isa_pkg::RET_A: begin
								verdict_accept <= ret_accept;
								state <= pf_isa_pkg::VERDICT;
							end
							default: begin
								verdict_accept <= 1'b0; // Unknown opcode
								state <= pf_isa_pkg::VERDICT;
							end
						endcase
					end
				end
				pf_isa_pkg::LOAD: begin
					pc <= pc_next; // Packet word arrived, ALU takes it now
					state <= pf_isa_pkg::FETCH;
				end
				default: state <= pf_isa_pkg::IDLE; // After the verdict pulse
			endcase
		end
	end

	assign pkt.accept = (state == pf_isa_pkg::VERDICT) && verdict_accept;
	assign pkt.reject = (state == pf_isa_pkg::VERDICT) && !verdict_accept;

	// Drop counter, saturating
	always_ff @(posedge clk) begin
		if (!rst_n || !start)
			drops <= 16'd0;
		else if (pkt.reject && drops != 16'hFFFF)
			drops <= drops + 1'b1;
	end

endmodule

// File: verilog/filt_regs.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module filt_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic [`PF_AXI_ADDR_WIDTH-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`PF_AXI_ADDR_WIDTH-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	input  logic [15:0] drops,
	output logic start,
	output logic [31:0] inst_low,
	output logic [31:0] inst_high,
	output logic inst_high_strobe
);
	logic [31:0] control_q; // Whole Control word for readback
	logic [31:0] rd_word;
	logic wr_accept;
	logic rd_accept;

	function automatic logic is_mapped(input logic [`PF_AXI_ADDR_WIDTH-1:0] addr);
		case (addr)
			pf_regmap_pkg::STATUS,
			pf_regmap_pkg::CONTROL,
			pf_regmap_pkg::INST_LOW,
			pf_regmap_pkg::INST_HIGH: is_mapped = 1'b1;
			default: is_mapped = 1'b0;
		endcase
	endfunction

	assign start = control_q[0];
	assign wr_accept = awvalid && wvalid && !bvalid && !awready; // Both halves present, no open response
	assign rd_accept = arvalid && !arready && !rvalid;

	// Read mux
	always_comb begin
		case (araddr)
			pf_regmap_pkg::STATUS: rd_word = {16'd0, drops};
			pf_regmap_pkg::CONTROL: rd_word = control_q;
			pf_regmap_pkg::INST_LOW: rd_word = inst_low;
			pf_regmap_pkg::INST_HIGH: rd_word = inst_high;
			default: rd_word = 32'd0;
		endcase
	end

	// Handshakes and control bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			control_q <= 32'd0;
			inst_high_strobe <= 1'b0;
		end else begin
			awready <= wr_accept; // One-cycle pulse
			wready <= wr_accept;
			inst_high_strobe <= awready && (awaddr == pf_regmap_pkg::INST_HIGH);
			if (awready) begin
				bvalid <= 1'b1; // Response the cycle after the handshake
				if (awaddr == pf_regmap_pkg::CONTROL)
					control_q <= wdata;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			arready <= rd_accept;
			if (arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0; // Held until taken
		end
	end

	// Data registers and responses
	always_ff @(posedge clk) begin
		if (awready) begin
			bresp <= is_mapped(awaddr) ? pf_regmap_pkg::OKAY : pf_regmap_pkg::SLVERR;
			if (awaddr == pf_regmap_pkg::INST_LOW)
				inst_low <= wdata; // Full word, strobes not honoured
			if (awaddr == pf_regmap_pkg::INST_HIGH)
				inst_high <= wdata;
		end
		if (arready) begin
			rdata <= rd_word;
			rresp <= is_mapped(araddr) ? pf_regmap_pkg::OKAY : pf_regmap_pkg::SLVERR;
		end
	end

endmodule

// File: verilog/inst_loader.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module inst_loader (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic [31:0] inst_low,
	input  logic [31:0] inst_high,
	input  logic inst_high_strobe,
	input  logic [`PF_CODE_ADDR_WIDTH-1:0] fetch_addr,
	output pf_isa_pkg::bpf_inst_t inst
);
	localparam int CODE_DEPTH = 2 ** `PF_CODE_ADDR_WIDTH;

	logic [63:0] code_mem [CODE_DEPTH]; // Instruction store
	logic [`PF_CODE_ADDR_WIDTH-1:0] wr_addr;
	logic wr_en;

	// Only loadable while the VM is stopped
	assign wr_en = inst_high_strobe && !start;

	// Write pointer
	always_ff @(posedge clk) begin
		if (!rst_n)
			wr_addr <= '0;
		else if (start)
			wr_addr <= '0; // Next load starts at instruction 0
		else if (wr_en)
			wr_addr <= wr_addr + 1'b1;
	end

	// Write port
	always_ff @(posedge clk) begin
		if (wr_en)
			code_mem[wr_addr] <= {inst_high, inst_low};
	end

	// Fetch port, registered
	always_ff @(posedge clk) begin
		inst <= pf_isa_pkg::bpf_inst_t'(code_mem[fetch_addr]);
	end

endmodule

// File: verilog/packet_buffer.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module packet_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic [`PF_PKT_ADDR_WIDTH-1:0] snooper_wr_addr,
	input  logic [`PF_PKT_DATA_WIDTH-1:0] snooper_wr_data,
	input  logic snooper_wr_en,
	input  logic snooper_done,
	output logic ready_for_snooper,
	input  logic [`PF_PKT_ADDR_WIDTH-1:0] forwarder_rd_addr,
	output logic [`PF_PKT_DATA_WIDTH-1:0] forwarder_rd_data,
	input  logic forwarder_rd_en,
	input  logic forwarder_done,
	output logic ready_for_forwarder,
	output logic [`PF_PKT_LEN_WIDTH-1:0] len_to_forwarder,
	pkt_if.target pkt
);
	localparam int PKT_DEPTH = 2 ** `PF_PKT_ADDR_WIDTH;

	pf_regmap_pkg::buf_state_e state;
	logic [`PF_PKT_DATA_WIDTH-1:0] mem [PKT_DEPTH];
	logic [`PF_PKT_DATA_WIDTH-1:0] rd_q;
	logic [`PF_PKT_ADDR_WIDTH-1:0] last_wr_addr;
	logic [`PF_PKT_ADDR_WIDTH-1:0] end_addr;
	logic [`PF_PKT_ADDR_WIDTH-1:0] rd_addr;
	logic [`PF_PKT_LEN_WIDTH-1:0] len_words;
	logic wr_ok;
	logic rd_en;

	assign ready_for_snooper = (state == pf_regmap_pkg::EMPTY);
	assign ready_for_forwarder = (state == pf_regmap_pkg::FORWARD);
	assign pkt.pkt_ready = (state == pf_regmap_pkg::FILTER);
	assign wr_ok = snooper_wr_en && ready_for_snooper; // Dropped otherwise
	assign end_addr = wr_ok ? snooper_wr_addr : last_wr_addr; // Done may share the last write

	// Read port belongs to the VM in FILTER, to the forwarder in FORWARD
	assign rd_addr = ready_for_forwarder ? forwarder_rd_addr : pkt.rd_addr;
	assign rd_en = ready_for_forwarder ? forwarder_rd_en : pkt.pkt_ready;

	assign pkt.rd_data = rd_q;
	assign forwarder_rd_data = rd_q;
	assign pkt.len_words = len_words;
	assign len_to_forwarder = len_words;

	// Ownership
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= pf_regmap_pkg::EMPTY;
		end else begin
			case (state)
				pf_regmap_pkg::EMPTY: if (snooper_done) state <= pf_regmap_pkg::FILTER;
				pf_regmap_pkg::FILTER: begin
					if (pkt.accept)
						state <= pf_regmap_pkg::FORWARD;
					else if (pkt.reject)
						state <= pf_regmap_pkg::EMPTY; // Discarded in place
				end
				pf_regmap_pkg::FORWARD: if (forwarder_done) state <= pf_regmap_pkg::EMPTY;
				default: state <= pf_regmap_pkg::EMPTY;
			endcase
		end
	end

	// Word memory and length capture
	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[snooper_wr_addr] <= snooper_wr_data;
			last_wr_addr <= snooper_wr_addr;
		end
		if (snooper_done && ready_for_snooper)
			len_words <= {1'b0, end_addr} + 1'b1; // Last address plus one
		if (rd_en)
			rd_q <= mem[rd_addr];
	end

endmodule

// File: verilog/packetfilt.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

module packetfilt (
	input  logic axi_aclk,
	input  logic rst_n,
	// AXI4-Lite slave
	input  logic [`PF_AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
	input  logic s_axi_awvalid,
	output logic s_axi_awready,
	input  logic [31:0] s_axi_wdata,
	input  logic [3:0] s_axi_wstrb,
	input  logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input  logic s_axi_bready,
	input  logic [`PF_AXI_ADDR_WIDTH-1:0] s_axi_araddr,
	input  logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [31:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input  logic s_axi_rready,
	// Snooper
	input  logic [`PF_PKT_ADDR_WIDTH-1:0] snooper_wr_addr,
	input  logic [`PF_PKT_DATA_WIDTH-1:0] snooper_wr_data,
	input  logic snooper_wr_en,
	input  logic snooper_done, // One-cycle pulse
	output logic ready_for_snooper,
	// Forwarder
	input  logic [`PF_PKT_ADDR_WIDTH-1:0] forwarder_rd_addr,
	output logic [`PF_PKT_DATA_WIDTH-1:0] forwarder_rd_data,
	input  logic forwarder_rd_en,
	input  logic forwarder_done, // One-cycle pulse
	output logic ready_for_forwarder,
	output logic [`PF_PKT_LEN_WIDTH-1:0] len_to_forwarder
);
	logic start;
	logic [31:0] inst_low;
	logic [31:0] inst_high;
	logic inst_high_strobe;
	logic [15:0] drops;
	logic [`PF_CODE_ADDR_WIDTH-1:0] fetch_addr;
	pf_isa_pkg::bpf_inst_t inst;

	alu_if alu_bus ();
	pkt_if pkt_bus ();

	filt_regs u_regs (
		.clk(axi_aclk), .rst_n(rst_n),
		.awaddr(s_axi_awaddr), .awvalid(s_axi_awvalid), .awready(s_axi_awready),
		.wdata(s_axi_wdata), .wstrb(s_axi_wstrb), .wvalid(s_axi_wvalid), .wready(s_axi_wready),
		.bresp(s_axi_bresp), .bvalid(s_axi_bvalid), .bready(s_axi_bready),
		.araddr(s_axi_araddr), .arvalid(s_axi_arvalid), .arready(s_axi_arready),
		.rdata(s_axi_rdata), .rresp(s_axi_rresp), .rvalid(s_axi_rvalid), .rready(s_axi_rready),
		.drops(drops), .start(start),
		.inst_low(inst_low), .inst_high(inst_high), .inst_high_strobe(inst_high_strobe)
	);

	inst_loader u_loader (
		.clk(axi_aclk), .rst_n(rst_n), .start(start),
		.inst_low(inst_low), .inst_high(inst_high), .inst_high_strobe(inst_high_strobe),
		.fetch_addr(fetch_addr), .inst(inst)
	);

	bpf_control u_control (
		.clk(axi_aclk), .rst_n(rst_n), .start(start),
		.fetch_addr(fetch_addr), .inst(inst),
		.alu(alu_bus.initiator), .pkt(pkt_bus.initiator), .drops(drops)
	);

	// Packet words go straight from the buffer read port into the ALU
	bpf_alu u_alu (
		.clk(axi_aclk), .rst_n(rst_n), .alu(alu_bus.target), .pkt_word(pkt_bus.rd_data)
	);

	packet_buffer u_buffer (
		.clk(axi_aclk), .rst_n(rst_n),
		.snooper_wr_addr(snooper_wr_addr), .snooper_wr_data(snooper_wr_data),
		.snooper_wr_en(snooper_wr_en), .snooper_done(snooper_done),
		.ready_for_snooper(ready_for_snooper),
		.forwarder_rd_addr(forwarder_rd_addr), .forwarder_rd_data(forwarder_rd_data),
		.forwarder_rd_en(forwarder_rd_en), .forwarder_done(forwarder_done),
		.ready_for_forwarder(ready_for_forwarder), .len_to_forwarder(len_to_forwarder),
		.pkt(pkt_bus.target)
	);

endmodule

// File: verilog/pf_if.sv
`timescale 1ns/10ps
`include "packetfilt_settings.svh"

// Sequencer to ALU
interface alu_if;
	pf_isa_pkg::alu_op_e op;
	logic [31:0] k; // Operand and compare value
	logic [1:0] byte_off; // Byte lane within the packet word
	logic [`PF_PKT_BYTES_WIDTH-1:0] pkt_len_bytes;
	logic [31:0] acc;
	logic eq_k;
	logic gt_k;
	logic set_k;

	modport initiator (output op, k, byte_off, pkt_len_bytes, input acc, eq_k, gt_k, set_k);
	modport target (input op, k, byte_off, output acc, eq_k, gt_k, set_k);
endinterface

// Sequencer to packet buffer
interface pkt_if;
	logic [`PF_PKT_ADDR_WIDTH-1:0] rd_addr;
	logic accept; // One cycle, never with reject
	logic reject;
	logic [`PF_PKT_DATA_WIDTH-1:0] rd_data; // One cycle after rd_addr
	logic [`PF_PKT_LEN_WIDTH-1:0] len_words;
	logic pkt_ready; // Buffer holds a packet to filter

	modport initiator (output rd_addr, accept, reject, input rd_data, len_words, pkt_ready);
	modport target (input rd_addr, accept, reject, output rd_data, len_words, pkt_ready);
endinterface

// File: verilog/pf_isa_pkg.sv
package pf_isa_pkg;

	// Classic BPF opcodes kept by this VM
	typedef enum logic [15:0] {
		LD_IMM    = 16'h0000, // A = k
		ALU_ADD_K = 16'h0004, // A = A + k
		RET_K     = 16'h0006,
		JEQ_K     = 16'h0015,
		RET_A     = 16'h0016,
		LD_W_ABS  = 16'h0020, // Word at byte offset k
		JGT_K     = 16'h0025,
		LD_H_ABS  = 16'h0028,
		LD_B_ABS  = 16'h0030,
		JSET_K    = 16'h0045, // Taken when A & k is nonzero
		ALU_AND_K = 16'h0054,
		LD_LEN    = 16'h0080  // A = packet length in bytes
	} bpf_opcode_e;

	// One 64-bit instruction, inst_high is opcode/jt/jf and inst_low is k
	typedef struct packed {
		bpf_opcode_e opcode;
		logic [7:0]  jt;
		logic [7:0]  jf;
		logic [31:0] k;
	} bpf_inst_t;

	typedef enum logic [2:0] {
		HOLD, LOAD_K, LOAD_B, LOAD_H, LOAD_W, ADD_K, AND_K
	} alu_op_e;

	typedef enum logic [2:0] {
		IDLE, FETCH, EXEC, LOAD, VERDICT
	} vm_state_e;

endpackage

// File: verilog/pf_regmap_pkg.sv
`include "packetfilt_settings.svh"

package pf_regmap_pkg;

	// Byte addresses inside the AXI window
	typedef enum logic [`PF_AXI_ADDR_WIDTH-1:0] {
		STATUS    = 12'h000, // Drop count in bits 15:0
		CONTROL   = 12'h004, // Bit 0 is start
		INST_LOW  = 12'h008,
		INST_HIGH = 12'h00C  // Writing it commits the instruction
	} reg_addr_e;

	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} axi_resp_e;

	// Who owns the packet buffer
	typedef enum logic [1:0] {
		EMPTY, FILTER, FORWARD
	} buf_state_e;

endpackage
